// ==== flist.f ====
hdl/nes_video_pkg.sv
hdl/video_cfg_if.sv
hdl/video_regs.sv
hdl/video_timing.sv
hdl/palette_rgb.sv
hdl/nes_video_top.sv
verif/nes_video_asserts.sv
verif/tb_nes_video.sv

// ==== Makefile ====
TOP := tb_nes_video

.PHONY: all build lint clean

all: build
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

build:
	verilator --binary --assert --timing --top-module $(TOP) -f flist.f

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir

// ==== verif/tb_nes_video.sv ====
module tb_nes_video;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_MAX = 2 * nes_video_pkg::FRAME_PERIOD;

  logic        clk;
  logic        rst;
  logic        i_psel;
  logic        i_penable;
  logic        i_pwrite;
  logic [7:0]  i_paddr;
  logic [31:0] i_pwdata;
  logic [31:0] o_prdata;
  logic        o_pready;
  logic        o_pslverr;
  logic [5:0]  i_palette_idx;
  logic [9:0]  o_nes_x;
  logic [9:0]  o_nes_y;
  logic [9:0]  o_nes_y_next;
  logic        o_pix_pulse;
  logic        o_sof;
  logic        o_hsync;
  logic        o_vblank;
  logic [2:0]  o_r;
  logic [2:0]  o_g;
  logic [1:0]  o_b;
  logic [5:0]  idx_tab [64];  // random picture content
  int          errors = 0;
  int          tests = 0;
  int          failed = 0;
  int          mark = 0;

  nes_video_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(40 * nes_video_pkg::FRAME_PERIOD * 4);
    $display("simulation ran past its time limit");
    $display("Something failed");
    $finish;
  end

  // picture processor answers in the same cycle
  assign i_palette_idx = idx_tab[{o_nes_y[2:0], o_nes_x[2:0]}];

  function automatic int fail_total();
    return errors + DUT.u_asserts.assert_fails;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int waits;
    @(negedge clk);
    i_psel    = 1'b1;        // setup
    i_penable = 1'b0;
    i_pwrite  = wr;
    i_paddr   = addr;
    i_pwdata  = wdata;
    @(negedge clk);
    i_penable = 1'b1;        // access
    waits     = 0;
    #1;
    while (o_pready !== 1'b1 && waits < 16) begin
      @(negedge clk);
      #1;
      waits++;
    end
    if (o_pready !== 1'b1) begin
      $display("APB transfer at address %h never got ready", addr);
      errors++;
    end
    rdata = o_prdata;
    err   = o_pslverr;
    @(negedge clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err);
    check_eq("o_pslverr", 32'(err), 32'(exp_err));
  endtask

  task automatic reg_read(input logic [7:0] addr, input logic [31:0] exp, input logic exp_err);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b0, addr, 32'h0, rd, err);
    check_eq("o_pslverr", 32'(err), 32'(exp_err));
    if (!exp_err)
      check_eq("o_prdata", rd, exp);
  endtask

  task automatic wait_frame_start();
    int n;
    n = 0;
    @(negedge clk);          // step past a frame start already in progress
    while (o_sof !== 1'b1 && n < WAIT_MAX) begin
      @(negedge clk);
      n++;
    end
    if (o_sof !== 1'b1) begin
      $display("no frame start within %0d cycles", WAIT_MAX);
      errors++;
    end
  endtask

  task automatic check_idle(input int cycles, input logic [7:0] bg);
    repeat (2) @(negedge clk);  // raster stops, last pixel drains
    repeat (cycles) begin
      @(negedge clk);
      check_eq("o_sof", 32'(o_sof), 32'd0);
      check_eq("o_pix_pulse", 32'(o_pix_pulse), 32'd0);
      check_eq("o_vblank", 32'(o_vblank), 32'd1);
      check_eq("{o_r, o_g, o_b}", 32'({o_r, o_g, o_b}), 32'(bg));
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    if (fail_total() != mark) begin
      failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: ok", name);
    end
    mark = fail_total();
  endtask

  initial begin
    void'($urandom(32'h55846573));
    foreach (idx_tab[i])
      idx_tab[i] = 6'($urandom());
    rst       = 1'b1;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
    i_paddr   = '0;
    i_pwdata  = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    reg_write(nes_video_pkg::ADDR_BG, 32'hA5, 1'b0);
    reg_write(nes_video_pkg::ADDR_XOFF, 32'd3, 1'b0);
    reg_write(nes_video_pkg::ADDR_YOFF, 32'd1, 1'b0);
    reg_write(nes_video_pkg::ADDR_FRAMES, 32'h1234, 1'b1); // read only
    reg_write(8'h14, 32'h1, 1'b1);                           // unmapped
    reg_read(nes_video_pkg::ADDR_CTRL, 32'h0, 1'b0);
    reg_read(nes_video_pkg::ADDR_BG, 32'hA5, 1'b0);
    reg_read(nes_video_pkg::ADDR_XOFF, 32'd3, 1'b0);
    reg_read(nes_video_pkg::ADDR_YOFF, 32'd1, 1'b0);
    reg_read(nes_video_pkg::ADDR_FRAMES, 32'h0, 1'b0);
    reg_read(8'h14, 32'h0, 1'b1);
    reg_write(nes_video_pkg::ADDR_CTRL, 32'h1, 1'b0);
    repeat (2) wait_frame_start();
    reg_read(nes_video_pkg::ADDR_FRAMES, 32'd2, 1'b0);
    reg_read(nes_video_pkg::ADDR_CTRL, 32'h1, 1'b0);
    end_test("registers");

    // raster and pixel path are watched by the bound assertions
    repeat (2) wait_frame_start();
    end_test("frame timing");

    // window against the right and bottom edges of the visible area
    reg_write(nes_video_pkg::ADDR_CTRL, 32'h0, 1'b0);
    reg_write(nes_video_pkg::ADDR_BG, 32'h1C, 1'b0);
    reg_write(nes_video_pkg::ADDR_XOFF, 32'd8, 1'b0);
    reg_write(nes_video_pkg::ADDR_YOFF, 32'd2, 1'b0);
    reg_write(nes_video_pkg::ADDR_CTRL, 32'h1, 1'b0);
    repeat (3) wait_frame_start();
    end_test("moved window");

    reg_write(nes_video_pkg::ADDR_CTRL, 32'h0, 1'b0);
    check_idle(2 * nes_video_pkg::FRAME_PERIOD, 8'h1C);
    end_test("disabled");

    $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
             tests, failed, errors, DUT.u_asserts.assert_fails);
    if (fail_total() == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// ==== verif/nes_video_asserts.sv ====
module nes_video_asserts (
  input logic                                clk,
  input logic                                rst,
  input logic                                i_enable,
  input logic [nes_video_pkg::RGB_W-1:0]     i_bg_color,
  input logic [nes_video_pkg::COORD_W-1:0]   i_x_offset,
  input logic [nes_video_pkg::COORD_W-1:0]   i_y_offset,
  input logic [nes_video_pkg::PIX_IDX_W-1:0] i_palette_idx,
  input logic [nes_video_pkg::COORD_W-1:0]   i_nes_x,
  input logic [nes_video_pkg::COORD_W-1:0]   i_nes_y,
  input logic [nes_video_pkg::COORD_W-1:0]   i_nes_y_next,
  input logic                                i_pix_pulse,
  input logic                                i_sof,
  input logic                                i_hsync,
  input logic                                i_vblank,
  input logic [2:0]                          i_r,
  input logic [2:0]                          i_g,
  input logic [1:0]                          i_b
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CW = nes_video_pkg::COORD_W;

  logic [CW-1:0] ras_x;
  logic [CW-1:0] ras_y;
  logic [CW-1:0] cur_x;
  logic [CW-1:0] cur_y;
  logic          scan_q;
  logic          cur_scan;
  logic          in_win;
  logic          coords_ok;
  logic          coords_zero;
  logic          seen_sof;
  logic [15:0]   gap;     // cycles since the last frame start
  logic [7:0]    rgb;
  int            assert_fails = 0;

  // reference raster, restarted by each frame start
  assign cur_scan = i_sof || scan_q;
  assign cur_x    = i_sof ? '0 : ras_x;
  assign cur_y    = i_sof ? '0 : ras_y;

  always_ff @(posedge clk) begin
    if (rst || !i_enable) begin
      scan_q <= 1'b0;
      ras_x  <= '0;
      ras_y  <= '0;
    end else if (cur_scan) begin
      if (cur_x == CW'(nes_video_pkg::LINE_LEN - 1)) begin
        ras_x  <= '0;
        ras_y  <= cur_y + CW'(1);
        scan_q <= cur_y != CW'(nes_video_pkg::FRAME_LINES - 1); // last line ends the frame
      end else begin
        ras_x  <= cur_x + CW'(1);
        ras_y  <= cur_y;
        scan_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst || !i_enable) begin
      seen_sof <= 1'b0;
      gap      <= '0;
    end else if (i_sof) begin
      seen_sof <= 1'b1;
      gap      <= 16'd1;
    end else if (gap != '1) begin
      gap <= gap + 16'd1;
    end
  end

  assign in_win = cur_scan &&
                  cur_x >= i_x_offset && cur_x < i_x_offset + CW'(nes_video_pkg::IMAGE_WIDTH) &&
                  cur_y >= i_y_offset && cur_y < i_y_offset + CW'(nes_video_pkg::IMAGE_HEIGHT);

  assign coords_ok   = i_nes_x == cur_x - i_x_offset && i_nes_y == cur_y - i_y_offset &&
                       i_nes_y_next == cur_y - i_y_offset + CW'(1);
  assign coords_zero = i_nes_x == '0 && i_nes_y == '0 && i_nes_y_next == '0;
  assign rgb         = {i_r, i_g, i_b};

  // frame starts a fixed period apart, each one right after the period pulse
  assert property (@(posedge clk) disable iff (rst)
    i_enable && (i_sof || seen_sof) |->
      (i_sof ? ($past(i_pix_pulse) && (!seen_sof || gap == 16'(nes_video_pkg::FRAME_PERIOD)))
             : (gap < 16'(nes_video_pkg::FRAME_PERIOD))))
    else begin
      $error("frame start spacing or period pulse wrong");
      assert_fails++;
    end

  assert property (@(posedge clk) disable iff (rst)
    $past(in_win) |->
      rgb == nes_video_pkg::palette_rgb_of($past(i_palette_idx)) && $past(coords_ok))
    else begin
      $error("pixel color or coordinates wrong inside the window");
      assert_fails++;
    end

  assert property (@(posedge clk) disable iff (rst)
    !$past(in_win) |-> rgb == $past(i_bg_color) && $past(coords_zero))
    else begin
      $error("background color or zero coordinates wrong outside the window");
      assert_fails++;
    end

  assert property (@(posedge clk) disable iff (rst)
    i_hsync == (cur_scan && cur_x < CW'(nes_video_pkg::FRAME_WIDTH)) &&
    i_vblank == (!cur_scan || cur_y >= CW'(nes_video_pkg::FRAME_HEIGHT)))
    else begin
      $error("hsync or vblank does not follow the raster");
      assert_fails++;
    end

endmodule

bind nes_video_top nes_video_asserts u_asserts (
  .clk           (clk),
  .rst           (rst),
  .i_enable      (cfg.enable),
  .i_bg_color    (cfg.bg_color),
  .i_x_offset    (cfg.x_offset),
  .i_y_offset    (cfg.y_offset),
  .i_palette_idx (i_palette_idx),
  .i_nes_x       (o_nes_x),
  .i_nes_y       (o_nes_y),
  .i_nes_y_next  (o_nes_y_next),
  .i_pix_pulse   (o_pix_pulse),
  .i_sof         (o_sof),
  .i_hsync       (o_hsync),
  .i_vblank      (o_vblank),
  .i_r           (o_r),
  .i_g           (o_g),
  .i_b           (o_b)
);

// ==== hdl/nes_video_top.sv ====
module nes_video_top (
  input  logic                                 clk,
  input  logic                                 rst,
  // apb config port
  input  logic                                 i_psel,
  input  logic                                 i_penable,
  input  logic                                 i_pwrite,
  input  logic [nes_video_pkg::APB_ADDR_W-1:0] i_paddr,
  input  logic [nes_video_pkg::APB_DATA_W-1:0] i_pwdata,
  output logic [nes_video_pkg::APB_DATA_W-1:0] o_prdata,
  output logic                                 o_pready,
  output logic                                 o_pslverr,
  // picture processor side
  input  logic [nes_video_pkg::PIX_IDX_W-1:0]  i_palette_idx,  // same-cycle answer
  output logic [nes_video_pkg::COORD_W-1:0]    o_nes_x,
  output logic [nes_video_pkg::COORD_W-1:0]    o_nes_y,
  output logic [nes_video_pkg::COORD_W-1:0]    o_nes_y_next,
  output logic                                 o_pix_pulse,
  // display side
  output logic                                 o_sof,
  output logic                                 o_hsync,
  output logic                                 o_vblank,
  output logic [2:0]                           o_r,
  output logic [2:0]                           o_g,
  output logic [1:0]                           o_b
);

  logic active;

  video_cfg_if cfg ();

  video_regs u_regs (
    .clk       (clk),
    .rst       (rst),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .o_prdata  (o_prdata),
    .o_pready  (o_pready),
    .o_pslverr (o_pslverr),
    .cfg       (cfg.regs_mp)
  );

  video_timing u_timing (
    .clk          (clk),
    .rst          (rst),
    .cfg          (cfg.video_mp),
    .o_active     (active),
    .o_nes_x      (o_nes_x),
    .o_nes_y      (o_nes_y),
    .o_nes_y_next (o_nes_y_next),
    .o_pix_pulse  (o_pix_pulse),
    .o_sof        (o_sof),
    .o_hsync      (o_hsync),
    .o_vblank     (o_vblank)
  );

  palette_rgb u_palette (
    .clk           (clk),
    .rst           (rst),
    .cfg           (cfg.video_mp),
    .i_active      (active),
    .i_palette_idx (i_palette_idx),
    .o_r           (o_r),
    .o_g           (o_g),
    .o_b           (o_b)
  );

endmodule

// ==== hdl/palette_rgb.sv ====
module palette_rgb (
  input  logic                                clk,
  input  logic                                rst,
  video_cfg_if.video_mp                       cfg,
  input  logic                                i_active,
  input  logic [nes_video_pkg::PIX_IDX_W-1:0] i_palette_idx,
  output logic [2:0]                          o_r,
  output logic [2:0]                          o_g,
  output logic [1:0]                          o_b
);

  logic [nes_video_pkg::RGB_W-1:0] rgb_next;
  logic [nes_video_pkg::RGB_W-1:0] rgb_q;

  // pick the picture color inside the window, background elsewhere
  always_comb begin
    if (i_active)
      rgb_next = nes_video_pkg::palette_rgb_of(i_palette_idx);
    else
      rgb_next = cfg.bg_color;
  end

  // one cycle behind the coordinate
  always_ff @(posedge clk) begin
    if (rst)
      rgb_q <= '0;
    else
      rgb_q <= rgb_next;
  end

  // 3-3-2 split
  assign o_r = rgb_q[7:5];
  assign o_g = rgb_q[4:2];
  assign o_b = rgb_q[1:0];

endmodule

// ==== hdl/video_timing.sv ====
module video_timing (
  input  logic                              clk,
  input  logic                              rst,
  video_cfg_if.video_mp                     cfg,
  output logic                              o_active,
  output logic [nes_video_pkg::COORD_W-1:0] o_nes_x,
  output logic [nes_video_pkg::COORD_W-1:0] o_nes_y,
  output logic [nes_video_pkg::COORD_W-1:0] o_nes_y_next,
  output logic                              o_pix_pulse,
  output logic                              o_sof,
  output logic                              o_hsync,
  output logic                              o_vblank
);

  localparam int CW = nes_video_pkg::COORD_W;

  typedef enum logic {ST_IDLE, ST_SCAN} state_t;

  state_t                              state;
  logic [nes_video_pkg::PERIOD_W-1:0]  period_cnt;
  logic [CW-1:0]                       x_pos;
  logic [CW-1:0]                       y_pos;
  logic                                line_end;
  logic                                frame_end;
  logic [CW:0]                         x_lim;  // one extra bit for the window end
  logic [CW:0]                         y_lim;
  logic                                in_x;
  logic                                in_y;

  // frame period counter, pulse once per period while enabled
  always_ff @(posedge clk) begin
    if (rst || !cfg.enable) begin
      period_cnt  <= '0;
      o_pix_pulse <= 1'b0;
    end else if (period_cnt == nes_video_pkg::PERIOD_W'(nes_video_pkg::FRAME_PERIOD - 1)) begin
      period_cnt  <= '0;
      o_pix_pulse <= 1'b1;
    end else begin
      period_cnt  <= period_cnt + 1'b1;
      o_pix_pulse <= 1'b0;
    end
  end

  assign line_end  = x_pos == CW'(nes_video_pkg::LINE_LEN - 1);
  assign frame_end = line_end && y_pos == CW'(nes_video_pkg::FRAME_LINES - 1);

  // raster walk
  always_ff @(posedge clk) begin
    if (rst || !cfg.enable) begin
      state <= ST_IDLE;
      x_pos <= '0;
      y_pos <= '0;
    end else if (o_pix_pulse) begin
      state <= ST_SCAN;  // frame starts next cycle at 0,0
      x_pos <= '0;
      y_pos <= '0;
    end else if (state == ST_SCAN) begin
      if (frame_end) begin
        state <= ST_IDLE;
        x_pos <= '0;
        y_pos <= '0;
      end else if (line_end) begin
        x_pos <= '0;
        y_pos <= y_pos + 1'b1;
      end else begin
        x_pos <= x_pos + 1'b1;
      end
    end
  end

  assign o_sof    = state == ST_SCAN && x_pos == '0 && y_pos == '0;
  assign o_hsync  = state == ST_SCAN && x_pos < CW'(nes_video_pkg::FRAME_WIDTH);
  assign o_vblank = state == ST_IDLE || y_pos >= CW'(nes_video_pkg::FRAME_HEIGHT);

  assign cfg.frame_strobe = o_sof;

  // image window
  assign x_lim    = {1'b0, cfg.x_offset} + (CW+1)'(nes_video_pkg::IMAGE_WIDTH);
  assign y_lim    = {1'b0, cfg.y_offset} + (CW+1)'(nes_video_pkg::IMAGE_HEIGHT);
  assign in_x     = x_pos >= cfg.x_offset && {1'b0, x_pos} < x_lim;
  assign in_y     = y_pos >= cfg.y_offset && {1'b0, y_pos} < y_lim;
  assign o_active = state == ST_SCAN && in_x && in_y;

  assign o_nes_x      = o_active ? x_pos - cfg.x_offset : '0;
  assign o_nes_y      = o_active ? y_pos - cfg.y_offset : '0;
  assign o_nes_y_next = o_active ? o_nes_y + 1'b1 : '0; // lookahead for the next line

endmodule

// ==== hdl/video_regs.sv ====
module video_regs (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   i_psel,
  input  logic                                   i_penable,
  input  logic                                   i_pwrite,
  input  logic [nes_video_pkg::APB_ADDR_W-1:0]   i_paddr,
  input  logic [nes_video_pkg::APB_DATA_W-1:0]   i_pwdata,
  output logic [nes_video_pkg::APB_DATA_W-1:0]   o_prdata,
  output logic                                   o_pready,
  output logic                                   o_pslverr,
  video_cfg_if.regs_mp                           cfg
);

  logic                                  access;
  logic                                  wr_en;
  logic                                  addr_ok;
  logic [nes_video_pkg::FRAME_CNT_W-1:0] frame_cnt;

  assign access   = i_psel && i_penable; // second phase of a transfer
  assign wr_en    = access && i_pwrite;
  assign o_pready = 1'b1;                 // no wait states

  // read mux and address decode
  always_comb begin
    o_prdata = '0;
    addr_ok  = 1'b1;
    case (i_paddr)
      nes_video_pkg::ADDR_CTRL:   o_prdata[0] = cfg.enable;
      nes_video_pkg::ADDR_BG:     o_prdata[nes_video_pkg::RGB_W-1:0] = cfg.bg_color;
      nes_video_pkg::ADDR_XOFF:   o_prdata[nes_video_pkg::COORD_W-1:0] = cfg.x_offset;
      nes_video_pkg::ADDR_YOFF:   o_prdata[nes_video_pkg::COORD_W-1:0] = cfg.y_offset;
      nes_video_pkg::ADDR_FRAMES: o_prdata[nes_video_pkg::FRAME_CNT_W-1:0] = frame_cnt;
      default:                    addr_ok = 1'b0;
    endcase
  end

  // frame count register cannot be written
  assign o_pslverr = access &&
                     (!addr_ok || (i_pwrite && i_paddr == nes_video_pkg::ADDR_FRAMES));

  always_ff @(posedge clk) begin
    if (rst) begin
      cfg.enable   <= 1'b0;
      cfg.bg_color <= '0;
      cfg.x_offset <= '0;
      cfg.y_offset <= '0;
      frame_cnt    <= '0;
    end else begin
      if (wr_en) begin
        case (i_paddr)
          nes_video_pkg::ADDR_CTRL: cfg.enable   <= i_pwdata[0];
          nes_video_pkg::ADDR_BG:   cfg.bg_color <= i_pwdata[nes_video_pkg::RGB_W-1:0];
          nes_video_pkg::ADDR_XOFF: cfg.x_offset <= i_pwdata[nes_video_pkg::COORD_W-1:0];
          nes_video_pkg::ADDR_YOFF: cfg.y_offset <= i_pwdata[nes_video_pkg::COORD_W-1:0];
          default: ;
        endcase
      end
      // writing enable low restarts the count
      if (wr_en && i_paddr == nes_video_pkg::ADDR_CTRL && !i_pwdata[0])
        frame_cnt <= '0;
      else if (cfg.frame_strobe)
        frame_cnt <= frame_cnt + 1'b1; // wraps
    end
  end

endmodule

// ==== hdl/video_cfg_if.sv ====
interface video_cfg_if;

  // configuration written over apb
  logic                              enable;
  logic [nes_video_pkg::RGB_W-1:0]   bg_color;   // fill outside the window
  logic [nes_video_pkg::COORD_W-1:0] x_offset;
  logic [nes_video_pkg::COORD_W-1:0] y_offset;

  // status back from the raster
  logic                              frame_strobe; // one cycle per frame start

  // register block side
  modport regs_mp (
    output enable,
    output bg_color,
    output x_offset,
    output y_offset,
    input  frame_strobe
  );

  // video pipeline side
  modport video_mp (
    input  enable,
    input  bg_color,
    input  x_offset,
    input  y_offset,
    output frame_strobe
  );

endinterface

// ==== hdl/nes_video_pkg.sv ====
package nes_video_pkg;

  // frame geometry, scaled down for simulation
  localparam int FRAME_WIDTH  = 16;  // visible columns
  localparam int HBLANK       = 4;
  localparam int LINE_LEN     = FRAME_WIDTH + HBLANK;
  localparam int FRAME_HEIGHT = 6;   // visible lines
  localparam int VBLANK       = 2;
  localparam int FRAME_LINES  = FRAME_HEIGHT + VBLANK;
  localparam int FRAME_PERIOD = 200; // cycles between frame starts, >= LINE_LEN * FRAME_LINES
  localparam int PERIOD_W     = $clog2(FRAME_PERIOD);

  // image window inside the visible area
  localparam int IMAGE_WIDTH  = 8;
  localparam int IMAGE_HEIGHT = 4;

  localparam int COORD_W      = 10;
  localparam int PIX_IDX_W    = 6;
  localparam int RGB_W        = 8;   // r3 g3 b2
  localparam int FRAME_CNT_W  = 16;

  // apb register map
  localparam int APB_ADDR_W   = 8;
  localparam int APB_DATA_W   = 32;
  localparam logic [APB_ADDR_W-1:0] ADDR_CTRL   = 8'h00; // bit 0 enable
  localparam logic [APB_ADDR_W-1:0] ADDR_BG     = 8'h04;
  localparam logic [APB_ADDR_W-1:0] ADDR_XOFF   = 8'h08;
  localparam logic [APB_ADDR_W-1:0] ADDR_YOFF   = 8'h0C;
  localparam logic [APB_ADDR_W-1:0] ADDR_FRAMES = 8'h10; // read only

  // approximation of the console system palette, 3-3-2 packed
  localparam logic [RGB_W-1:0] PALETTE [64] = '{
    8'h6D, 8'h22, 8'h02, 8'h42, 8'h81, 8'hA0, 8'hA0, 8'h60,
    8'h44, 8'h08, 8'h08, 8'h04, 8'h05, 8'h00, 8'h00, 8'h00,
    8'hB6, 8'h0F, 8'h27, 8'h83, 8'hA2, 8'hE1, 8'hC4, 8'hC8,
    8'h8C, 8'h10, 8'h14, 8'h10, 8'h12, 8'h00, 8'h00, 8'h00,
    8'hFF, 8'h37, 8'h53, 8'hB3, 8'hEF, 8'hEE, 8'hED, 8'hF0,
    8'hF4, 8'h98, 8'h59, 8'h5E, 8'h1F, 8'h00, 8'h00, 8'h00,
    8'hFF, 8'hBF, 8'hDB, 8'hDB, 8'hFB, 8'hFB, 8'hF6, 8'hFA,
    8'hFE, 8'hFE, 8'hBE, 8'hBF, 8'h9F, 8'h00, 8'h00, 8'h00
  };

  // palette index to packed color
  function automatic logic [RGB_W-1:0] palette_rgb_of(input logic [PIX_IDX_W-1:0] idx);
    return PALETTE[idx];
  endfunction

endpackage
